//--- include/dcache_consts.svh
/*
 * data cache controller constants
 *   set-index width of the flush and eviction sweep
 *   reset and clear value of the set index
 *   reset value of the controller state register
 */

`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// 256 sets
`define DCACHE_IDX_BITS     8

// index after reset, after a kill and at the end of a sweep
`define DCACHE_IDX_RESET    {`DCACHE_IDX_BITS{1'b0}}

// controller wakes up idle
`define DCACHE_STATE_RESET  dcache_state_pkg::DCACHE_IDLE

`endif

//--- design/dcache_state_pkg.sv
/*
 * controller-internal encodings
 *   dcache_state_e  seven-state controller FSM, 3-bit
 *   idx_op_e        opcode from the FSM to the set-index counter
 */

package dcache_state_pkg;

    // main controller states
    typedef enum logic [2:0] {
        DCACHE_IDLE        = 3'd0,
        DCACHE_PROCESS_REQ = 3'd1,
        DCACHE_ALLOCATE    = 3'd2,
        DCACHE_WRITE_BACK  = 3'd3,
        DCACHE_FLUSH       = 3'd4,
        DCACHE_FLUSH_NEXT  = 3'd5,
        DCACHE_FLUSH_DONE  = 3'd6
    } dcache_state_e;

    // set-index counter commands
    typedef enum logic [1:0] {
        IDX_HOLD  = 2'd0,
        IDX_INC   = 2'd1,
        IDX_CLEAR = 2'd2
    } idx_op_e;

endpackage

//--- design/dcache_port_pkg.sv
/*
 * port bundles of the data cache controller
 *   dcache_op_e     load/store opcode from the LSU
 *   lsu_req_t       LSU request flag and opcode
 *   array_status_t  lookup result from the tag/data arrays
 *   array_cmd_t     one-cycle strobes toward the arrays
 *   mem_cmd_t       request, write and kill toward memory
 */

package dcache_port_pkg;

    // access type
    typedef enum logic {
        DCACHE_OP_LOAD  = 1'b0,
        DCACHE_OP_STORE = 1'b1
    } dcache_op_e;

    // LSU side, held until ack
    typedef struct packed {
        logic       req;
        dcache_op_e op;
    } lsu_req_t;

    // array lookup status, valid in the cycle it is read
    typedef struct packed {
        // tag match at the current lookup
        logic hit;
        // selected line is dirty
        logic evict_req;
    } array_status_t;

    // array strobes, all act in the same cycle
    typedef struct packed {
        // store data into the hit line
        logic cache_wr;
        // fill the line from memory
        logic line_wr;
        // clear the dirty bit
        logic line_clean;
        // array drives write-back data
        logic wrb_req;
    } array_cmd_t;

    // memory side
    typedef struct packed {
        // held until mem ack
        logic req;
        // write-back when set, line fill otherwise
        logic wr;
        // combinational abort strobe
        logic kill;
    } mem_cmd_t;

endpackage

//--- design/set_index_counter.sv
/*
 * set_index_counter
 *   set index of the flush sweep and the eviction
 *   clear, saturating increment and hold
 *   last-index flag for the FSM
 */

`timescale 1ns/1ps
`include "dcache_consts.svh"

module set_index_counter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  dcache_state_pkg::idx_op_e     idx_op_i,
    output logic [`DCACHE_IDX_BITS-1:0]   index_o,
    output logic                          last_o
);

    logic [`DCACHE_IDX_BITS-1:0] index_ff;
    logic                        at_last;

    // all ones means the final set of the sweep
    assign at_last = &index_ff;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            index_ff <= `DCACHE_IDX_RESET;
        end else begin
            case (idx_op_i)
                dcache_state_pkg::IDX_CLEAR: begin
                    index_ff <= `DCACHE_IDX_RESET;
                end
                dcache_state_pkg::IDX_INC: begin
                    // stick at the last set, no wrap
                    if (!at_last) begin
                        index_ff <= index_ff + 1'b1;
                    end
                end
                default: begin
                    index_ff <= index_ff;
                end
            endcase
        end
    end

    assign index_o = index_ff;
    assign last_o  = at_last;

endmodule

//--- design/dcache_ctrl_fsm.sv
/*
 * dcache_ctrl_fsm
 *   sampling registers for LSU request, opcode and dmem select
 *   hit qualification
 *   seven-state controller for hit, miss, write-back, allocate and flush
 *   kill override toward memory
 */

`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_ctrl_fsm (
    input  logic                            clk,
    input  logic                            rst_n,

    // LSU side
    input  dcache_port_pkg::lsu_req_t       lsu_req_i,
    input  logic                            dmem_sel_i,
    input  logic                            kill_i,
    input  logic                            flush_i,
    output logic                            lsu_ack_o,

    // tag/data arrays
    input  dcache_port_pkg::array_status_t  array_status_i,
    output dcache_port_pkg::array_cmd_t     array_cmd_o,

    // memory side
    input  logic                            mem_ack_i,
    output dcache_port_pkg::mem_cmd_t       mem_cmd_o,

    // set-index counter
    input  logic                            idx_last_i,
    output dcache_state_pkg::idx_op_e       idx_op_o
);

    ////////////////////////////////////////////////////////////////////////////
    // request sampling
    ////////////////////////////////////////////////////////////////////////////

    logic                         req_ff;
    logic                         dmem_sel_ff;
    dcache_port_pkg::dcache_op_e  op_ff;
    logic                         lsu_hit;
    logic                         is_store;
    logic                         abort;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_ff      <= 1'b0;
            dmem_sel_ff <= 1'b0;
            op_ff       <= dcache_port_pkg::DCACHE_OP_LOAD;
        end else begin
            req_ff      <= lsu_req_i.req;
            dmem_sel_ff <= dmem_sel_i;
            op_ff       <= lsu_req_i.op;
        end
    end

    // hit only counts for a request that was really aimed at dmem
    assign lsu_hit  = req_ff & dmem_sel_ff & array_status_i.hit;
    assign is_store = (op_ff == dcache_port_pkg::DCACHE_OP_STORE);

    // kill or deselect drops whatever is in flight
    assign abort    = kill_i | ~dmem_sel_i;

    ////////////////////////////////////////////////////////////////////////////
    // state register
    ////////////////////////////////////////////////////////////////////////////

    dcache_state_pkg::dcache_state_e  state_ff;
    dcache_state_pkg::dcache_state_e  state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_ff <= `DCACHE_STATE_RESET;
        end else begin
            state_ff <= state_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // next state and strobes
    ////////////////////////////////////////////////////////////////////////////

    logic                         ack;
    dcache_port_pkg::array_cmd_t  arr_cmd;
    dcache_port_pkg::mem_cmd_t    mem_cmd;
    dcache_state_pkg::idx_op_e    idx_op;

    always_comb begin
        state_next = state_ff;
        idx_op     = dcache_state_pkg::IDX_HOLD;
        ack        = 1'b0;
        arr_cmd    = '0;
        mem_cmd    = '0;

        case (state_ff)
            dcache_state_pkg::DCACHE_IDLE: begin
                // flush wins over a plain request
                if (flush_i) begin
                    state_next = dcache_state_pkg::DCACHE_FLUSH;
                end else if (lsu_req_i.req) begin
                    state_next = dcache_state_pkg::DCACHE_PROCESS_REQ;
                end else begin
                    // nothing pending, park index at set 0
                    idx_op = dcache_state_pkg::IDX_CLEAR;
                end
            end

            dcache_state_pkg::DCACHE_PROCESS_REQ: begin
                if (lsu_hit) begin
                    // one-cycle ack, store data lands with it
                    ack              = 1'b1;
                    arr_cmd.cache_wr = is_store;
                    state_next       = dcache_state_pkg::DCACHE_IDLE;
                end else if (array_status_i.evict_req) begin
                    // dirty victim goes out first
                    mem_cmd.req     = 1'b1;
                    mem_cmd.wr      = 1'b1;
                    arr_cmd.wrb_req = 1'b1;
                    state_next      = dcache_state_pkg::DCACHE_WRITE_BACK;
                end else begin
                    // clean miss, fetch straight away
                    mem_cmd.req = 1'b1;
                    state_next  = dcache_state_pkg::DCACHE_ALLOCATE;
                end
            end

            dcache_state_pkg::DCACHE_ALLOCATE: begin
                if (mem_ack_i) begin
                    // fill line, then redo the lookup
                    arr_cmd.line_wr = 1'b1;
                    state_next      = dcache_state_pkg::DCACHE_PROCESS_REQ;
                end else begin
                    mem_cmd.req = 1'b1;
                end
            end

            dcache_state_pkg::DCACHE_WRITE_BACK: begin
                if (mem_ack_i) begin
                    if (flush_i) begin
                        // line is now clean, move on to the next set
                        arr_cmd.line_clean = 1'b1;
                        idx_op             = dcache_state_pkg::IDX_INC;
                        state_next         = dcache_state_pkg::DCACHE_FLUSH_NEXT;
                    end else begin
                        // miss path, start the fill right away
                        mem_cmd.req = 1'b1;
                        state_next  = dcache_state_pkg::DCACHE_ALLOCATE;
                    end
                end else begin
                    // hold the write-back until memory takes it
                    mem_cmd.req     = 1'b1;
                    mem_cmd.wr      = 1'b1;
                    arr_cmd.wrb_req = 1'b1;
                end
            end

            dcache_state_pkg::DCACHE_FLUSH: begin
                if (array_status_i.evict_req) begin
                    mem_cmd.req     = 1'b1;
                    mem_cmd.wr      = 1'b1;
                    arr_cmd.wrb_req = 1'b1;
                    state_next      = dcache_state_pkg::DCACHE_WRITE_BACK;
                end else if (idx_last_i) begin
                    // sweep finished
                    idx_op     = dcache_state_pkg::IDX_CLEAR;
                    state_next = dcache_state_pkg::DCACHE_FLUSH_DONE;
                end else begin
                    idx_op     = dcache_state_pkg::IDX_INC;
                    state_next = dcache_state_pkg::DCACHE_FLUSH_NEXT;
                end
            end

            // one idle cycle so the array sees the new index
            dcache_state_pkg::DCACHE_FLUSH_NEXT: begin
                state_next = dcache_state_pkg::DCACHE_FLUSH;
            end

            dcache_state_pkg::DCACHE_FLUSH_DONE: begin
                ack        = 1'b1;
                state_next = dcache_state_pkg::DCACHE_IDLE;
            end

            default: begin
                state_next = dcache_state_pkg::DCACHE_IDLE;
            end
        endcase

        // kill override, applied after everything else
        if (abort) begin
            state_next       = dcache_state_pkg::DCACHE_IDLE;
            idx_op           = dcache_state_pkg::IDX_CLEAR;
            arr_cmd.cache_wr = 1'b0;
            mem_cmd.req      = 1'b0;
            mem_cmd.kill     = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////////////////////

    assign lsu_ack_o   = ack;
    assign array_cmd_o = arr_cmd;
    assign mem_cmd_o   = mem_cmd;
    assign idx_op_o    = idx_op;

endmodule

//--- design/wb_dcache_ctrl.sv
/*
 * wb_dcache_ctrl
 *   write-back, write-allocate data cache controller top
 *   controller FSM plus flush/eviction set-index counter
 */

`timescale 1ns/1ps
`include "dcache_consts.svh"

module wb_dcache_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,

    // LSU side
    input  dcache_port_pkg::lsu_req_t       lsu_req_i,
    input  logic                            dmem_sel_i,
    input  logic                            kill_i,
    input  logic                            flush_i,
    output logic                            lsu_ack_o,

    // tag/data arrays
    input  dcache_port_pkg::array_status_t  array_status_i,
    output dcache_port_pkg::array_cmd_t     array_cmd_o,
    output logic [`DCACHE_IDX_BITS-1:0]     evict_index_o,

    // memory side
    input  logic                            mem_ack_i,
    output dcache_port_pkg::mem_cmd_t       mem_cmd_o
);

    // FSM to counter
    dcache_state_pkg::idx_op_e  idx_op;
    logic                       idx_last;

    // controller
    dcache_ctrl_fsm u_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .lsu_req_i      (lsu_req_i),
        .dmem_sel_i     (dmem_sel_i),
        .kill_i         (kill_i),
        .flush_i        (flush_i),
        .lsu_ack_o      (lsu_ack_o),
        .array_status_i (array_status_i),
        .array_cmd_o    (array_cmd_o),
        .mem_ack_i      (mem_ack_i),
        .mem_cmd_o      (mem_cmd_o),
        .idx_last_i     (idx_last),
        .idx_op_o       (idx_op)
    );

    // set index, also addresses the arrays during eviction
    set_index_counter u_idx (
        .clk      (clk),
        .rst_n    (rst_n),
        .idx_op_i (idx_op),
        .index_o  (evict_index_o),
        .last_o   (idx_last)
    );

endmodule

//--- testbench/tb_wb_dcache_ctrl.sv
/*
 * testbench for the write-back data cache controller
 *   clock, reset, LCG
 *   memory model with random ack delay, dirty-bit array model
 *   directed tests for hits, misses, flush and kill
 */

`timescale 1ns/1ps
`include "dcache_consts.svh"

module tb_wb_dcache_ctrl;

    logic                            clk;
    logic                            rst_n;
    dcache_port_pkg::lsu_req_t       lsu_req;
    logic                            dmem_sel_i;
    logic                            kill_i;
    logic                            flush_i;
    logic                            lsu_ack_o;
    logic                            arr_hit;
    logic                            arr_evict;
    dcache_port_pkg::array_status_t  array_status;
    dcache_port_pkg::array_cmd_t     array_cmd_o;
    logic [`DCACHE_IDX_BITS-1:0]     evict_index_o;
    logic                            mem_ack_i;
    dcache_port_pkg::mem_cmd_t       mem_cmd_o;

    // model state
    bit          dirty [256];
    bit          mem_log [$];
    int unsigned clean_log [$];
    bit          mem_busy;
    bit          mem_cur_wr;
    bit          mem_stall;
    int unsigned mem_delay;
    int unsigned lcg_state;
    int          errors;
    int          n_pass;
    int          n_fail;

    assign array_status = {arr_hit, arr_evict};

    wb_dcache_ctrl uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .lsu_req_i      (lsu_req),
        .dmem_sel_i     (dmem_sel_i),
        .kill_i         (kill_i),
        .flush_i        (flush_i),
        .lsu_ack_o      (lsu_ack_o),
        .array_status_i (array_status),
        .array_cmd_o    (array_cmd_o),
        .evict_index_o  (evict_index_o),
        .mem_ack_i      (mem_ack_i),
        .mem_cmd_o      (mem_cmd_o)
    );

    always #5 clk = ~clk;

    function automatic int unsigned rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // memory and array models
    ////////////////////////////////////////////////////////////////////////////

    // pre-edge values, flops update later in the NBA region
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_busy  = 1'b0;
            mem_delay = 0;
        end else begin
            if (array_cmd_o.line_clean) begin
                clean_log.push_back(evict_index_o);
                dirty[evict_index_o] = 1'b0;
            end
            if (mem_ack_i && mem_busy) begin
                mem_log.push_back(mem_cur_wr);
                mem_busy = 1'b0;
            end else if (mem_cmd_o.req && !mem_busy) begin
                mem_busy   = 1'b1;
                mem_cur_wr = mem_cmd_o.wr;
                mem_delay  = rand_next() % 6;
            end else if (mem_busy && !mem_cmd_o.req) begin
                // request withdrawn by a kill
                mem_busy = 1'b0;
            end else if (mem_busy && mem_delay != 0) begin
                mem_delay = mem_delay - 1;
            end
        end
    end

    always @(negedge clk) begin
        mem_ack_i <= mem_busy && (mem_delay == 0) && !mem_stall;
        arr_evict <= dirty[evict_index_o];
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
        $display("Mismatch %s: got %h expected %h at %0t", sig, got, exp, $time);
        errors++;
    endtask

    task automatic complain(input string msg);
        $display("%s at %0t", msg, $time);
        errors++;
    endtask

    // one line per finished test
    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            n_pass++;
            $display("test %s: pass", name);
        end else begin
            n_fail++;
            $display("test %s: FAIL", name);
        end
    endtask

    // falling edge, then let outputs settle
    task automatic step();
        @(negedge clk);
        #1;
    endtask

    // load or store that hits, ack exactly one cycle after the request
    task automatic run_hit(input bit store);
        int mem_before;
        mem_before = mem_log.size();
        @(negedge clk);
        lsu_req.req = 1'b1;
        lsu_req.op  = store ? dcache_port_pkg::DCACHE_OP_STORE : dcache_port_pkg::DCACHE_OP_LOAD;
        arr_hit     = 1'b1;
        #1;
        assert (lsu_ack_o == 1'b0) else mismatch("lsu_ack_o", lsu_ack_o, 0);
        step();
        assert (lsu_ack_o == 1'b1) else mismatch("lsu_ack_o", lsu_ack_o, 1);
        assert (array_cmd_o.cache_wr == store) else mismatch("cache_wr", array_cmd_o.cache_wr, store);
        assert (mem_cmd_o.req == 1'b0) else mismatch("mem_cmd_o.req", mem_cmd_o.req, 0);
        @(negedge clk);
        lsu_req.req = 1'b0;
        arr_hit     = 1'b0;
        assert (mem_log.size() == mem_before) else complain("memory access on a hit");
    endtask

    // miss sequence until lsu ack, returns the memory transactions seen
    task automatic run_miss(input bit store, output bit wb_then_rd, output int n_tr);
        int  start;
        bit  saw_fill;
        bit  in_wb;
        bit  in_rd;
        bit  got_ack;
        start    = mem_log.size();
        saw_fill = 1'b0;
        in_wb    = 1'b0;
        in_rd    = 1'b0;
        got_ack  = 1'b0;
        @(negedge clk);
        lsu_req.req = 1'b1;
        lsu_req.op  = store ? dcache_port_pkg::DCACHE_OP_STORE : dcache_port_pkg::DCACHE_OP_LOAD;
        for (int i = 0; i < 60 && !got_ack; i++) begin
            @(negedge clk);
            // raise hit once the line has been filled
            if (saw_fill) arr_hit = 1'b1;
            #1;
            if (mem_cmd_o.wr && !in_wb && !mem_ack_i) in_wb = 1'b1;
            if (mem_cmd_o.req && !mem_cmd_o.wr && !in_wb && !mem_ack_i) in_rd = 1'b1;
            if (in_wb && !mem_ack_i) begin
                assert (mem_cmd_o.req && mem_cmd_o.wr && array_cmd_o.wrb_req)
                    else mismatch("mem_cmd_o", mem_cmd_o, 3'b110);
            end
            if (in_wb && mem_ack_i) in_wb = 1'b0;
            // fill request holds with wr low until the memory acks
            if (in_rd && !mem_ack_i) begin
                assert (mem_cmd_o.req && !mem_cmd_o.wr)
                    else mismatch("mem_cmd_o", mem_cmd_o, 3'b100);
            end
            if (in_rd && mem_ack_i) begin
                assert (array_cmd_o.line_wr) else complain("no line_wr in the fill ack cycle");
                in_rd = 1'b0;
            end
            if (array_cmd_o.line_wr) begin
                assert (mem_ack_i) else complain("line_wr without a memory ack");
                saw_fill = 1'b1;
            end
            if (lsu_ack_o) begin
                got_ack = 1'b1;
                assert (array_cmd_o.cache_wr == store)
                    else mismatch("cache_wr", array_cmd_o.cache_wr, store);
            end
        end
        assert (got_ack) else complain("timeout waiting for lsu ack after miss");
        @(negedge clk);
        lsu_req.req = 1'b0;
        arr_hit     = 1'b0;
        n_tr        = mem_log.size() - start;
        wb_then_rd  = (n_tr == 2) && mem_log[start] && !mem_log[start+1];
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_hits();
        int e0;
        e0 = errors;
        step();
        assert (lsu_ack_o == 1'b0) else mismatch("lsu_ack_o", lsu_ack_o, 0);
        assert (array_cmd_o == '0) else mismatch("array_cmd_o", array_cmd_o, 0);
        assert (mem_cmd_o.req == 1'b0) else mismatch("mem_cmd_o.req", mem_cmd_o.req, 0);
        run_hit(1'b0);
        run_hit(1'b1);
        report_test("reset_hits", e0);
    endtask

    task automatic test_clean_miss();
        int e0;
        int n_tr;
        bit order;
        e0 = errors;
        run_miss(1'b0, order, n_tr);
        assert (n_tr == 1) else mismatch("mem transactions", n_tr, 1);
        assert (n_tr != 1 || !mem_log[mem_log.size()-1]) else complain("fill was a write");
        report_test("clean_miss", e0);
    endtask

    task automatic test_dirty_miss();
        int e0;
        int n_tr;
        bit order;
        e0 = errors;
        // index parks at set 0 in idle
        dirty[0] = 1'b1;
        run_miss(1'b1, order, n_tr);
        assert (n_tr == 2) else mismatch("mem transactions", n_tr, 2);
        assert (order) else complain("write-back did not come before the fill");
        dirty[0] = 1'b0;
        report_test("dirty_miss", e0);
    endtask

    task automatic test_flush();
        int e0;
        int n_dirty;
        int start;
        int n_ack;
        bit expect_clean [256];
        e0      = errors;
        n_dirty = 0;
        n_ack   = 0;
        start   = mem_log.size();
        clean_log.delete();
        for (int i = 0; i < 20; i++) begin
            dirty[rand_next() % 256] = 1'b1;
        end
        for (int i = 0; i < 256; i++) begin
            expect_clean[i] = dirty[i];
            n_dirty += dirty[i];
        end
        @(negedge clk);
        flush_i = 1'b1;
        for (int i = 0; i < 2000 && n_ack == 0; i++) begin
            step();
            if (lsu_ack_o) n_ack++;
        end
        assert (n_ack == 1) else complain("timeout waiting for flush ack");
        @(negedge clk);
        flush_i = 1'b0;
        // no second ack once flush is released
        for (int i = 0; i < 4; i++) begin
            step();
            assert (!lsu_ack_o) else complain("extra ack after flush");
        end
        assert (mem_log.size() - start == n_dirty)
            else mismatch("write-backs", mem_log.size() - start, n_dirty);
        // every flush transaction is a write-back
        for (int i = start; i < mem_log.size(); i++) begin
            assert (mem_log[i]) else complain("read transaction during flush");
        end
        assert (clean_log.size() == n_dirty)
            else mismatch("line_clean count", clean_log.size(), n_dirty);
        foreach (clean_log[k]) begin
            assert (expect_clean[clean_log[k]])
                else complain($sformatf("line_clean at set %0h that was not dirty", clean_log[k]));
            expect_clean[clean_log[k]] = 1'b0;
        end
        assert (evict_index_o == '0) else mismatch("evict_index_o", evict_index_o, 0);
        for (int i = 0; i < 256; i++) begin
            assert (!dirty[i]) else complain("dirty line left after flush");
        end
        report_test("flush", e0);
    endtask

    task automatic test_kill();
        int e0;
        int n_req;
        e0    = errors;
        n_req = 0;
        mem_stall = 1'b1;
        @(negedge clk);
        lsu_req.req = 1'b1;
        lsu_req.op  = dcache_port_pkg::DCACHE_OP_LOAD;
        // second cycle with mem req is allocate
        for (int i = 0; i < 10 && n_req < 2; i++) begin
            step();
            if (mem_cmd_o.req) n_req++;
        end
        assert (n_req == 2) else complain("timeout waiting for the fill request");
        @(negedge clk);
        kill_i      = 1'b1;
        lsu_req.req = 1'b0;
        #1;
        assert (mem_cmd_o.kill) else mismatch("mem_cmd_o.kill", mem_cmd_o.kill, 1);
        assert (!mem_cmd_o.req) else mismatch("mem_cmd_o.req", mem_cmd_o.req, 0);
        assert (!lsu_ack_o) else mismatch("lsu_ack_o", lsu_ack_o, 0);
        @(negedge clk);
        kill_i = 1'b0;
        for (int i = 0; i < 4; i++) begin
            step();
            assert (!lsu_ack_o && !mem_cmd_o.req) else complain("activity after kill");
        end
        mem_stall = 1'b0;
        run_hit(1'b0);

        // deselect in the middle of a flush
        mem_stall = 1'b1;
        dirty[3]  = 1'b1;
        @(negedge clk);
        flush_i = 1'b1;
        n_req   = 0;
        for (int i = 0; i < 40 && n_req == 0; i++) begin
            step();
            if (mem_cmd_o.req && mem_cmd_o.wr) n_req++;
        end
        assert (n_req == 1) else complain("timeout waiting for flush write-back");
        @(negedge clk);
        dmem_sel_i = 1'b0;
        #1;
        assert (mem_cmd_o.kill) else mismatch("mem_cmd_o.kill", mem_cmd_o.kill, 1);
        assert (!mem_cmd_o.req) else mismatch("mem_cmd_o.req", mem_cmd_o.req, 0);
        @(negedge clk);
        dmem_sel_i = 1'b1;
        flush_i    = 1'b0;
        // dirty set 3 is still there, a live sweep would request it again
        for (int i = 0; i < 4; i++) begin
            step();
            assert (!lsu_ack_o && !mem_cmd_o.req) else complain("flush still active after deselect");
        end
        mem_stall = 1'b0;
        dirty[3]  = 1'b0;
        report_test("kill", e0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        lsu_req     = '0;
        dmem_sel_i  = 1'b1;
        kill_i      = 1'b0;
        flush_i     = 1'b0;
        arr_hit     = 1'b0;
        arr_evict   = 1'b0;
        mem_ack_i   = 1'b0;
        mem_stall   = 1'b0;
        lcg_state   = 32'he068f691;
        errors      = 0;
        n_pass      = 0;
        n_fail      = 0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        test_reset_hits();
        test_clean_miss();
        test_dirty_miss();
        test_flush();
        test_kill();

        $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // overall limit in case a wait loop misbehaves
    initial begin
        #200000;
        $display("global timeout, the run did not finish");
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- wb_dcache_ctrl.f
+incdir+include
design/dcache_state_pkg.sv
design/dcache_port_pkg.sv
design/set_index_counter.sv
design/dcache_ctrl_fsm.sv
design/wb_dcache_ctrl.sv
testbench/tb_wb_dcache_ctrl.sv

//--- Makefile
# Verilator build and run for the data cache controller

LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f wb_dcache_ctrl.f \
		--top-module tb_wb_dcache_ctrl -o Vtb_wb_dcache_ctrl
	./obj_dir/Vtb_wb_dcache_ctrl 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "FAIL"; exit 1; \
	elif ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

lint:
	verilator --lint-only -Wall +incdir+include \
		design/dcache_state_pkg.sv design/dcache_port_pkg.sv \
		design/set_index_counter.sv design/dcache_ctrl_fsm.sv \
		design/wb_dcache_ctrl.sv --top-module wb_dcache_ctrl

clean:
	rm -rf obj_dir $(LOG)
